// ==== src.f ====
+incdir+tb
src/opl3_pkg.sv
src/host_port.sv
src/register_file.sv
src/interval_timers.sv
src/key_scan.sv
src/opl3_ctrl_top.sv
tb/opl3_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the OPL3 control testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
        --top-module opl3_ctrl_tb -o opl3_ctrl_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/opl3_ctrl_sim); then
    echo "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$sim_out"

if grep -q "^ALL TESTS PASSED$" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== tb/tb_bus_tasks.svh ====
// Host bus tasks and helpers
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// 16-bit Galois LFSR, taps 16,14,13,11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic reg_data_t rand_byte();
    reg_data_t v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
        lfsr_state = lfsr_step(lfsr_state);  // one step per bit
        v = {v[6:0], lfsr_state[0]};
    end
    return v;
endfunction

// one strobe, then idle so accesses are 3 cycles apart
task automatic bus_cycle(input logic is_rd, input logic [1:0] a, input reg_data_t d);
    cs        = 1'b1;
    rd        = is_rd;
    wr        = !is_rd;
    host_addr = a;
    host_din  = d;
    @(negedge clk);
    cs = 1'b0;
    rd = 1'b0;
    wr = 1'b0;
    @(negedge clk);
    @(negedge clk);
endtask

task automatic write_reg(input logic bank, input reg_addr_t addr, input reg_data_t d);
    bus_cycle(1'b0, {bank, 1'b0}, addr);
    bus_cycle(1'b0, {bank, 1'b1}, d);
endtask

task automatic read_reg(input logic bank, input reg_addr_t addr, output reg_data_t d);
    bus_cycle(1'b0, {bank, 1'b0}, addr);
    bus_cycle(1'b1, {bank, 1'b1}, 8'h00);
    d = host_dout;  // two edges after the strobe
endtask

task automatic read_status(output reg_data_t s);
    bus_cycle(1'b1, 2'b00, 8'h00);
    s = host_dout;
endtask

task automatic wait_status(input reg_data_t mask, input int max_reads,
                           output reg_data_t s, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    s    = '0;
    while (!seen && n < max_reads) begin
        read_status(s);
        seen = (s & mask) == mask;
        n++;
    end
endtask

task automatic wait_key_event(input int max_cycles, output bit seen);
    int n;
    n    = 0;
    seen = key_events.size() > 0;
    while (!seen && n < max_cycles) begin
        @(negedge clk);
        n++;
        seen = key_events.size() > 0;
    end
endtask

task automatic idle_cycles(input int count);
    for (int i = 0; i < count; i++)
        @(negedge clk);
endtask

`endif

// ==== tb/opl3_ctrl_tb.sv ====
// OPL3 control testbench
`timescale 1ns/1ps

module opl3_ctrl_tb;
    import opl3_pkg::*;

    localparam reg_addr_t OP_ROWS [5] = '{8'h20, 8'h40, 8'h60, 8'h80, 8'hE0};
    localparam reg_addr_t HOLES [4]   = '{8'h06, 8'h07, 8'h0E, 8'h0F};

    logic        clk;
    logic        rst_n;
    logic        cs;
    logic        rd;
    logic        wr;
    logic [1:0]  host_addr;
    reg_data_t   host_din;
    reg_data_t   host_dout;
    logic        irq;
    logic        key_on;
    logic        key_off;
    chan_t       key_ch;
    fnum_t       key_fnum;
    block_t      key_block;

    int          error_count;
    int          test_count;
    int          test_errors;
    logic [15:0] lfsr_state;
    logic [19:0] key_events [$];  // {on, off, ch, fnum, block}
    reg_data_t   written [NUM_BANKS][5][NUM_OPERATORS];

    opl3_ctrl_top opl3_ctrl_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs        (cs),
        .rd        (rd),
        .wr        (wr),
        .host_addr (host_addr),
        .host_din  (host_din),
        .host_dout (host_dout),
        .irq       (irq),
        .key_on    (key_on),
        .key_off   (key_off),
        .key_ch    (key_ch),
        .key_fnum  (key_fnum),
        .key_block (key_block)
    );

    `include "tb_bus_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (key_on || key_off)
            key_events.push_back({key_on, key_off, key_ch, key_fnum, key_block});
    end

    // status irq bit is the OR of the two flags
    assert property (@(posedge clk) disable iff (!rst_n)
                     (cs && rd && !host_addr[0]) |=>
                     (host_dout == {host_dout[6] | host_dout[5], host_dout[6:5], 5'b00000}))
        else begin
            $display("CHECK FAILED at %0t ns: host_dout = %0h, expected %0h", $time,
                     host_dout, {host_dout[6] | host_dout[5], host_dout[6:5], 5'b00000});
            error_count++;
        end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
            else begin
                $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h",
                         $time, name, got, exp);
                error_count++;
            end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_errors)
            $display("test %0d %s: ok", test_count, name);
        else
            $display("test %0d %s: %0d errors", test_count, name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // slot offset of an operator within its row
    function automatic int op_slot(input int op);
        return (op / 6) * 8 + op % 6;
    endfunction

    initial begin
        reg_data_t   got;
        reg_data_t   s;
        reg_data_t   fl;
        reg_data_t   hi;
        reg_data_t   bv;
        reg_addr_t   a;
        logic [19:0] ev;
        bit          seen;
        bit          bit6_seen;
        int          n;

        rst_n       = 1'b0;
        cs          = 1'b0;
        rd          = 1'b0;
        wr          = 1'b0;
        host_addr   = 2'b00;
        host_din    = 8'h00;
        error_count = 0;
        test_count  = 0;
        test_errors = 0;
        lfsr_state  = 16'd11046;
        idle_cycles(4);
        rst_n = 1'b1;
        idle_cycles(2);
        check_value("host_dout", host_dout, 8'h00);
        check_value("irq", irq, 0);
        end_test("reset values");

        for (int b = 0; b < NUM_BANKS; b++)
            for (int r = 0; r < 5; r++)
                for (int o = 0; o < NUM_OPERATORS; o++) begin
                    written[b][r][o] = rand_byte();
                    write_reg(b[0], reg_addr_t'(OP_ROWS[r] + op_slot(o)), written[b][r][o]);
                end
        for (int b = 0; b < NUM_BANKS; b++)
            for (int r = 0; r < 5; r++)
                for (int o = 0; o < NUM_OPERATORS; o++) begin
                    a = reg_addr_t'(OP_ROWS[r] + op_slot(o));
                    read_reg(b[0], a, got);
                    check_value($sformatf("readback bank %0d reg %02h", b, a), got,
                                (r == 4) ? (written[b][r][o] & 8'h07) : written[b][r][o]);
                end
        end_test("operator round trip");

        for (int b = 0; b < NUM_BANKS; b++)
            for (int r = 0; r < 5; r++)
                for (int h = 0; h < 4; h++) begin
                    a = reg_addr_t'(OP_ROWS[r] + HOLES[h]);
                    read_reg(b[0], a, got);
                    check_value($sformatf("hole bank %0d reg %02h", b, a), got, 8'hFF);
                end
        read_reg(1'b1, 8'h04, got);
        check_value("bank 1 reg 04", got, 8'hFF);
        write_reg(1'b0, 8'h08, 8'h40);
        write_reg(1'b1, 8'h08, 8'h00);  // bank-0-only register
        read_reg(1'b0, 8'h08, got);
        check_value("bank 0 reg 08", got, 8'h40);
        end_test("unmapped locations");

        for (int b = 0; b < NUM_BANKS; b++) begin
            n  = int'(rand_byte()) % NUM_CHANNELS;
            fl = rand_byte();
            hi = rand_byte();
            bv = {2'b00, 1'b1, hi[4:0]};
            write_reg(b[0], reg_addr_t'(8'hA0 + n), fl);
            key_events.delete();
            write_reg(b[0], reg_addr_t'(8'hB0 + n), bv);
            wait_key_event(24, seen);
            if (!seen) begin
                $display("no key_on event for bank %0d channel %0d", b, n);
                error_count++;
            end else begin
                ev = key_events.pop_front();
                check_value("key_on", ev[19], 1);
                check_value("key_ch", ev[17:13], b * NUM_CHANNELS + n);
                check_value("key_fnum", ev[12:3], {hi[1:0], fl});
                check_value("key_block", ev[2:0], hi[4:2]);
            end
            key_events.delete();
            write_reg(b[0], reg_addr_t'(8'hB0 + n), bv);  // same kon again
            idle_cycles(24);
            check_value("key event count", key_events.size(), 0);
            write_reg(b[0], reg_addr_t'(8'hB0 + n), bv & 8'hDF);
            wait_key_event(24, seen);
            if (!seen) begin
                $display("no key_off event for bank %0d channel %0d", b, n);
                error_count++;
            end else begin
                ev = key_events.pop_front();
                check_value("key_off", ev[18], 1);
                check_value("key_ch", ev[17:13], b * NUM_CHANNELS + n);
            end
        end
        end_test("key events");

        write_reg(1'b0, 8'h02, 8'hFC);
        write_reg(1'b0, 8'h04, 8'h01);
        wait_status(8'hC0, 40, s, seen);
        if (!seen) begin
            $display("timer 1 flag did not set in time");
            error_count++;
        end else begin
            check_value("status", s & 8'hE0, 8'hC0);
            check_value("irq", irq, 1);
        end
        write_reg(1'b0, 8'h04, 8'h80);  // irq reset, timers stopped
        read_status(s);
        check_value("status", s, 8'h00);
        check_value("irq", irq, 0);
        end_test("timer 1 overflow");

        write_reg(1'b0, 8'h04, 8'h41);
        bit6_seen = 1'b0;
        for (int i = 0; i < 24; i++) begin
            read_status(s);
            bit6_seen = bit6_seen | s[6];
        end
        check_value("status bit 6 masked", bit6_seen, 0);
        write_reg(1'b0, 8'h03, 8'hFE);
        write_reg(1'b0, 8'h04, 8'h42);
        wait_status(8'h20, 50, s, seen);
        if (!seen) begin
            $display("timer 2 flag did not set in time");
            error_count++;
        end else begin
            check_value("status", s & 8'hE0, 8'hA0);
            check_value("irq", irq, 1);
        end
        write_reg(1'b0, 8'h04, 8'h80);
        read_status(s);
        check_value("status", s, 8'h00);
        end_test("mask and timer 2");

        $display("tests %0d, errors %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src/opl3_ctrl_top.sv ====
// OPL3 control top level
`timescale 1ns/1ps

module opl3_ctrl_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cs,
    input  logic                rd,
    input  logic                wr,
    input  logic [1:0]          host_addr,
    input  opl3_pkg::reg_data_t host_din,
    output opl3_pkg::reg_data_t host_dout,
    output logic                irq,
    output logic                key_on,
    output logic                key_off,
    output opl3_pkg::chan_t     key_ch,
    output opl3_pkg::fnum_t     key_fnum,
    output opl3_pkg::block_t    key_block
);
    import opl3_pkg::*;

    logic      reg_wr;
    logic      reg_rd;
    logic      reg_bank;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    timer_t    timer1;
    timer_t    timer2;
    logic      mt1;
    logic      mt2;
    logic      st1;
    logic      st2;
    logic      irq_rst;
    logic      ft1;
    logic      ft2;
    logic      kon   [NUM_BANKS][NUM_CHANNELS];
    fnum_t     fnum  [NUM_BANKS][NUM_CHANNELS];
    block_t    block [NUM_BANKS][NUM_CHANNELS];

    host_port host_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs        (cs),
        .rd        (rd),
        .wr        (wr),
        .host_addr (host_addr),
        .host_din  (host_din),
        .host_dout (host_dout),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_bank  (reg_bank),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .irq       (irq),
        .ft1       (ft1),
        .ft2       (ft2)
    );

    // operator fields wait for the synthesis engine
    register_file register_file_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (reg_wr),
        .rd          (reg_rd),
        .bank_select (reg_bank),
        .address     (reg_addr),
        .data_in     (reg_wdata),
        .data_out    (reg_rdata),
        .timer1      (timer1),
        .timer2      (timer2),
        .irq_rst     (irq_rst),
        .mt1         (mt1),
        .mt2         (mt2),
        .st1         (st1),
        .st2         (st2),
        .fnum        (fnum),
        .block       (block),
        .kon         (kon),
        .is_new (), .nts (), .dvb (), .dam (), .connection_sel (),
        .cha (), .chb (), .chc (), .chd (), .fb (), .cnt (),
        .mult (), .ws (), .vib (), .ar (), .dr (), .sl (), .rr (),
        .tl (), .ksr (), .ksl (), .egt (), .am (),
        .ryt (), .bd (), .sd (), .tom (), .tc (), .hh ()
    );

    interval_timers interval_timers_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .timer1  (timer1),
        .timer2  (timer2),
        .st1     (st1),
        .st2     (st2),
        .mt1     (mt1),
        .mt2     (mt2),
        .irq_rst (irq_rst),
        .ft1     (ft1),
        .ft2     (ft2),
        .irq     (irq)
    );

    key_scan key_scan_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .kon       (kon),
        .fnum      (fnum),
        .block     (block),
        .key_on    (key_on),
        .key_off   (key_off),
        .key_ch    (key_ch),
        .key_fnum  (key_fnum),
        .key_block (key_block)
    );

endmodule

// ==== src/key_scan.sv ====
// Key-on edge scanner
`timescale 1ns/1ps

module key_scan (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              kon   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    input  opl3_pkg::fnum_t   fnum  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    input  opl3_pkg::block_t  block [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic              key_on,
    output logic              key_off,
    output opl3_pkg::chan_t   key_ch,
    output opl3_pkg::fnum_t   key_fnum,
    output opl3_pkg::block_t  key_block
);
    import opl3_pkg::*;

    chan_t                     ch;
    logic                      scan_bank;
    logic [3:0]                scan_idx;
    logic                      cur_kon;
    logic [TOTAL_CHANNELS-1:0] kon_seen;  // last reported state

    assign scan_bank = ch >= chan_t'(NUM_CHANNELS);
    assign scan_idx  = scan_bank ? 4'(ch - chan_t'(NUM_CHANNELS)) : ch[3:0];
    assign cur_kon   = kon[scan_bank][scan_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch       <= '0;
            key_on   <= 1'b0;
            key_off  <= 1'b0;
            kon_seen <= '0;
        end else begin
            ch      <= (ch == chan_t'(TOTAL_CHANNELS - 1)) ? '0 : ch + 1'b1;
            key_on  <= cur_kon && !kon_seen[ch];
            key_off <= !cur_kon && kon_seen[ch];
            kon_seen[ch] <= cur_kon;
        end
    end

    always_ff @(posedge clk) begin
        key_ch    <= ch;
        key_fnum  <= fnum[scan_bank][scan_idx];
        key_block <= block[scan_bank][scan_idx];
    end

endmodule

// ==== src/interval_timers.sv ====
// Interval timers
`timescale 1ns/1ps

module interval_timers (
    input  logic             clk,
    input  logic             rst_n,
    input  opl3_pkg::timer_t timer1,
    input  opl3_pkg::timer_t timer2,
    input  logic             st1,
    input  logic             st2,
    input  logic             mt1,
    input  logic             mt2,
    input  logic             irq_rst,
    output logic             ft1,
    output logic             ft2,
    output logic             irq
);
    import opl3_pkg::*;

    logic [TICK_CNT_WIDTH-1:0] presc;
    logic [DIV_CNT_WIDTH-1:0]  div2;
    logic                      tick;
    logic                      tick2;
    logic [1:0]                start;
    logic [1:0]                mask;
    logic [1:0]                step;
    logic [1:0]                was_started;  // start edge detect
    logic [1:0]                ovf;
    logic [1:0]                flag;
    timer_t                    preset [2];
    timer_t                    count  [2];

    assign tick  = presc == TICK_CNT_WIDTH'(TICK_CYCLES - 1);
    assign tick2 = tick && (div2 == DIV_CNT_WIDTH'(TIMER2_DIV - 1));

    assign start     = {st2, st1};
    assign mask      = {mt2, mt1};
    assign step      = {tick2, tick};
    assign preset[0] = timer1;
    assign preset[1] = timer2;

    always_comb begin
        for (int t = 0; t < 2; t++)
            ovf[t] = start[t] && step[t] && (count[t] == TIMER_MAX);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc       <= '0;
            div2        <= '0;
            was_started <= 2'b00;
            flag        <= 2'b00;
            count[0]    <= '0;
            count[1]    <= '0;
        end else begin
            presc       <= tick ? '0 : presc + 1'b1;
            was_started <= start;
            if (tick)
                div2 <= tick2 ? '0 : div2 + 1'b1;
            for (int t = 0; t < 2; t++) begin
                if (start[t] && !was_started[t])
                    count[t] <= preset[t];
                else if (ovf[t])
                    count[t] <= preset[t];  // reload past FF
                else if (start[t] && step[t])
                    count[t] <= count[t] + 1'b1;
                if (irq_rst)
                    flag[t] <= 1'b0;
                else if (ovf[t] && !mask[t])
                    flag[t] <= 1'b1;
            end
        end
    end

    assign ft1 = flag[0];
    assign ft2 = flag[1];
    assign irq = ft1 | ft2;

endmodule

// ==== src/register_file.sv ====
// Two-bank register map
`timescale 1ns/1ps

module register_file (
    input  logic clk,
    input  logic rst_n,
    input  logic wr,
    input  logic rd,
    input  logic bank_select,
    input  opl3_pkg::reg_addr_t address,
    input  opl3_pkg::reg_data_t data_in,
    output opl3_pkg::reg_data_t data_out,
    output opl3_pkg::timer_t timer1,
    output opl3_pkg::timer_t timer2,
    output logic irq_rst,
    output logic mt1,
    output logic mt2,
    output logic st1,
    output logic st2,
    output logic is_new,
    output logic nts,
    output logic dvb,
    output logic dam,
    output logic [opl3_pkg::CONNECTION_SEL_WIDTH-1:0] connection_sel,
    output opl3_pkg::fnum_t fnum [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output opl3_pkg::block_t block [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic kon [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic cha [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chb [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chc [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chd [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic [opl3_pkg::FB_WIDTH-1:0] fb [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic cnt [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic [opl3_pkg::MULT_WIDTH-1:0] mult [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::WS_WIDTH-1:0] ws [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic vib [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::ENV_WIDTH-1:0] ar [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::ENV_WIDTH-1:0] dr [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::ENV_WIDTH-1:0] sl [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::ENV_WIDTH-1:0] rr [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::TL_WIDTH-1:0] tl [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic ksr [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::KSL_WIDTH-1:0] ksl [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic egt [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic am [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic ryt,
    output logic bd,
    output logic sd,
    output logic tom,
    output logic tc,
    output logic hh
);
    import opl3_pkg::*;

    logic       op_ok;
    logic [4:0] op_idx;
    logic       ch_ok;
    logic [3:0] ch_idx;
    reg_data_t  rd_mux;

    // slots 6,7,E,F and 16 up are holes in each operator row
    assign op_ok  = !(address[2] && address[1]) && !(address[4] && address[3]);
    assign op_idx = {3'b000, address[4:3]} * 5'd6 + {2'b00, address[2:0]};
    assign ch_idx = address[3:0];
    assign ch_ok  = ch_idx < 4'(NUM_CHANNELS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer1         <= '0;
            timer2         <= '0;
            {irq_rst, mt1, mt2, st2, st1} <= 5'b00000;
            connection_sel <= '0;
            is_new         <= 1'b0;
            nts            <= 1'b0;
            {dam, dvb, ryt, bd, sd, tom, tc, hh} <= 8'h00;
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPERATORS; o++) begin
                    {am[b][o], vib[b][o], egt[b][o], ksr[b][o], mult[b][o]} <= 8'h00;
                    {ksl[b][o], tl[b][o]} <= 8'h00;
                    {ar[b][o], dr[b][o]}  <= 8'h00;
                    {sl[b][o], rr[b][o]}  <= 8'h00;
                    ws[b][o] <= '0;
                end
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    {kon[b][c], block[b][c], fnum[b][c]} <= 14'h0000;
                    {chd[b][c], chc[b][c], chb[b][c], cha[b][c], fb[b][c], cnt[b][c]} <= 8'h00;
                end
            end
        end else if (wr) begin
            case (address)
                ADDR_TIMER1: if (!bank_select) timer1 <= data_in;
                ADDR_TIMER2: if (!bank_select) timer2 <= data_in;
                ADDR_CTRL: begin
                    if (!bank_select)
                        {irq_rst, mt1, mt2, st2, st1} <= {data_in[7:5], data_in[1:0]};
                    else
                        connection_sel <= data_in[CONNECTION_SEL_WIDTH-1:0];
                end
                ADDR_NEW:    if (bank_select) is_new <= data_in[0];
                ADDR_NTS:    if (!bank_select) nts <= data_in[6];
                ADDR_RHYTHM: if (!bank_select) {dam, dvb, ryt, bd, sd, tom, tc, hh} <= data_in;
                default: begin
                    if (op_ok) begin
                        case (address[7:5])
                            3'h1: {am[bank_select][op_idx], vib[bank_select][op_idx],
                                   egt[bank_select][op_idx], ksr[bank_select][op_idx],
                                   mult[bank_select][op_idx]} <= data_in;
                            3'h2: {ksl[bank_select][op_idx], tl[bank_select][op_idx]} <= data_in;
                            3'h3: {ar[bank_select][op_idx], dr[bank_select][op_idx]} <= data_in;
                            3'h4: {sl[bank_select][op_idx], rr[bank_select][op_idx]} <= data_in;
                            3'h7: ws[bank_select][op_idx] <= data_in[2:0];
                            default: ;
                        endcase
                    end
                    if (ch_ok) begin
                        case (address[7:4])
                            4'hA: fnum[bank_select][ch_idx][7:0] <= data_in;
                            4'hB: {kon[bank_select][ch_idx], block[bank_select][ch_idx],
                                   fnum[bank_select][ch_idx][9:8]} <= data_in[5:0];
                            4'hC: {chd[bank_select][ch_idx], chc[bank_select][ch_idx],
                                   chb[bank_select][ch_idx], cha[bank_select][ch_idx],
                                   fb[bank_select][ch_idx], cnt[bank_select][ch_idx]} <= data_in;
                            default: ;
                        endcase
                    end
                end
            endcase
        end
    end

    always_comb begin
        rd_mux = READ_UNMAPPED;
        case (address)
            ADDR_TIMER1: if (!bank_select) rd_mux = timer1;
            ADDR_TIMER2: if (!bank_select) rd_mux = timer2;
            ADDR_CTRL:   if (!bank_select) rd_mux = {irq_rst, mt1, mt2, 3'b000, st2, st1};
            ADDR_NEW:    if (bank_select) rd_mux = {7'b0000000, is_new};
            ADDR_NTS:    if (!bank_select) rd_mux = {1'b0, nts, 6'b000000};
            ADDR_RHYTHM: if (!bank_select) rd_mux = {dam, dvb, ryt, bd, sd, tom, tc, hh};
            default: begin
                if (op_ok) begin
                    case (address[7:5])
                        3'h1: rd_mux = {am[bank_select][op_idx], vib[bank_select][op_idx],
                                        egt[bank_select][op_idx], ksr[bank_select][op_idx],
                                        mult[bank_select][op_idx]};
                        3'h2: rd_mux = {ksl[bank_select][op_idx], tl[bank_select][op_idx]};
                        3'h3: rd_mux = {ar[bank_select][op_idx], dr[bank_select][op_idx]};
                        3'h4: rd_mux = {sl[bank_select][op_idx], rr[bank_select][op_idx]};
                        3'h7: rd_mux = {5'b00000, ws[bank_select][op_idx]};
                        default: ;
                    endcase
                end
                if (ch_ok) begin
                    case (address[7:4])
                        4'hA: rd_mux = fnum[bank_select][ch_idx][7:0];
                        4'hB: rd_mux = {2'b00, kon[bank_select][ch_idx],
                                        block[bank_select][ch_idx],
                                        fnum[bank_select][ch_idx][9:8]};
                        4'hC: rd_mux = {chd[bank_select][ch_idx], chc[bank_select][ch_idx],
                                        chb[bank_select][ch_idx], cha[bank_select][ch_idx],
                                        fb[bank_select][ch_idx], cnt[bank_select][ch_idx]};
                        default: ;
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd)
            data_out <= rd_mux;
    end

endmodule

// ==== src/host_port.sv ====
// Host bus port
`timescale 1ns/1ps

module host_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cs,
    input  logic               rd,
    input  logic               wr,
    input  logic [1:0]         host_addr,
    input  opl3_pkg::reg_data_t host_din,
    output opl3_pkg::reg_data_t host_dout,
    output logic               reg_wr,
    output logic               reg_rd,
    output logic               reg_bank,
    output opl3_pkg::reg_addr_t reg_addr,
    output opl3_pkg::reg_data_t reg_wdata,
    input  opl3_pkg::reg_data_t reg_rdata,
    input  logic               irq,
    input  logic               ft1,
    input  logic               ft2
);
    import opl3_pkg::*;

    logic      addr_wr;
    logic      data_wr;
    logic      data_rd;
    logic      last_data_rd;  // host_dout source select
    reg_data_t status_q;

    assign addr_wr = cs && wr && !host_addr[0];
    assign data_wr = cs && wr && host_addr[0];
    assign data_rd = cs && rd && host_addr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr       <= 1'b0;
            reg_rd       <= 1'b0;
            reg_addr     <= '0;
            reg_bank     <= 1'b0;
            last_data_rd <= 1'b0;
            status_q     <= '0;
        end else begin
            reg_wr <= data_wr;
            reg_rd <= data_rd;
            if (addr_wr) begin
                reg_addr <= host_din;
                reg_bank <= host_addr[1];
            end
            if (cs && rd) begin
                last_data_rd <= host_addr[0];
                if (!host_addr[0])
                    status_q <= {irq, ft1, ft2, 5'b00000};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr)
            reg_wdata <= host_din;
    end

    // readback arrives one edge after reg_rd
    assign host_dout = last_data_rd ? reg_rdata : status_q;

endmodule

// ==== src/opl3_pkg.sv ====
// OPL3 control definitions
package opl3_pkg;

    localparam int NUM_BANKS      = 2;
    localparam int NUM_CHANNELS   = 9;   // per bank
    localparam int NUM_OPERATORS  = 18;  // per bank
    localparam int TOTAL_CHANNELS = NUM_BANKS * NUM_CHANNELS;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [7:0] timer_t;
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;
    typedef logic [4:0] chan_t;  // bank * 9 + channel

    localparam int MULT_WIDTH           = 4;
    localparam int ENV_WIDTH            = 4;
    localparam int TL_WIDTH             = 6;
    localparam int KSL_WIDTH            = 2;
    localparam int WS_WIDTH             = 3;
    localparam int FB_WIDTH             = 3;
    localparam int CONNECTION_SEL_WIDTH = 6;

    // fixed locations in the map
    localparam reg_addr_t ADDR_TIMER1 = 8'h02;
    localparam reg_addr_t ADDR_TIMER2 = 8'h03;
    localparam reg_addr_t ADDR_CTRL   = 8'h04;
    localparam reg_addr_t ADDR_NEW    = 8'h05;  // bank 1 only
    localparam reg_addr_t ADDR_NTS    = 8'h08;
    localparam reg_addr_t ADDR_RHYTHM = 8'hBD;

    localparam reg_data_t READ_UNMAPPED = 8'hFF;

    localparam int     TICK_CYCLES    = 8;  // short for simulation
    localparam int     TIMER2_DIV     = 4;
    localparam int     TICK_CNT_WIDTH = $clog2(TICK_CYCLES);
    localparam int     DIV_CNT_WIDTH  = $clog2(TIMER2_DIV);
    localparam timer_t TIMER_MAX      = 8'hFF;

endpackage
